// ==== rtl/vga_cfg.svh ====
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// word addresses on wb adr 4:1, byte 0 is the even port
`define VGA_ADR_ATTR    4'h0  // 3c0/3c1 attribute index/data
`define VGA_ADR_SEQ     4'h2  // 3c4 index, 3c5 data
`define VGA_ADR_PEL_RD  4'h3  // 3c6 pel mask, 3c7 dac read address
`define VGA_ADR_PEL_WR  4'h4  // 3c8 dac write address, 3c9 dac data
`define VGA_ADR_GFX     4'h7  // 3ce index, 3cf data
`define VGA_ADR_CRTC    4'hA  // 3d4 index, 3d5 data
`define VGA_ADR_STATUS  4'hD  // 3da input status 1

// ram depths
`define VGA_PAL_ENTRIES 16
`define VGA_DAC_ENTRIES 256   // three colour bytes each

`endif

// ==== rtl/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  // wishbone slave request, word addressed
  typedef struct packed {
    logic [15:0] dat;
    logic [3:0]  adr;  // adr 4:1
    logic        we;
    logic [1:0]  sel;
    logic        stb;
  } wb_req_t;

  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } wb_rsp_t;

  // decoded graphics controller fields
  typedef struct packed {
    logic       shift_reg1;       // gfx 5 bit 6
    logic       graphics_alpha;   // gfx 6 bit 0
    logic       memory_mapping1;  // gfx 6 bit 3
    logic [1:0] write_mode;       // gfx 5
    logic [1:0] raster_op;        // gfx 3
    logic       read_mode;        // gfx 5 bit 3
    logic [7:0] bitmask;          // gfx 8
    logic [3:0] set_reset;        // gfx 0
    logic [3:0] enable_set_reset; // gfx 1
    logic [1:0] read_map_select;  // gfx 4
    logic [3:0] color_compare;    // gfx 2
    logic [3:0] color_dont_care;  // gfx 7
  } gfx_ctrl_t;

  // crtc fields, regs 10..15
  typedef struct packed {
    logic [5:0]  cur_start;
    logic [5:0]  cur_end;
    logic [15:0] start_addr;  // {reg 12, reg 13}
    logic [4:0]  vcursor;
    logic [6:0]  hcursor;
  } crtc_t;

  typedef struct packed {
    logic [3:0] addr;
    logic       we;
    logic [7:0] wdata;
  } pal_port_t;

  // shared by write and read side, we unused on read
  typedef struct packed {
    logic [7:0] entry;
    logic [1:0] cycle;  // 0 red, 1 green, 2 blue
    logic       we;
    logic [7:0] wdata;
  } dac_port_t;

  // byte written to 3c0, meaning set by the flip-flop
  typedef union packed {
    struct packed {
      logic [2:0] rsvd;
      logic       pas;    // palette address source, bit 4
      logic [3:0] index;
    } idx;
    logic [7:0] color;
  } attr_byte_u;

endpackage

`default_nettype wire

// ==== rtl/vga_palette_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_cfg.svh"

module vga_palette_ram (
  input  wire                     wb_clk_i,
  input  wire vga_pkg::pal_port_t pal_i,
  output logic [7:0]              rdata_o
);

  logic [7:0] mem [`VGA_PAL_ENTRIES];  // one byte per attribute colour

  always_ff @(posedge wb_clk_i)
  begin
    if (pal_i.we)
      mem[pal_i.addr] <= pal_i.wdata;
  end

  // registered read, always at the current index
  always_ff @(posedge wb_clk_i)
  begin
    rdata_o <= mem[pal_i.addr];
  end

endmodule

`default_nettype wire

// ==== rtl/vga_dac_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_cfg.svh"

module vga_dac_ram (
  input  wire                     wb_clk_i,
  input  wire vga_pkg::dac_port_t wr_i,
  input  wire vga_pkg::dac_port_t rd_i,
  output logic [7:0]              rdata_o
);

  localparam int unsigned DEPTH = `VGA_DAC_ENTRIES * 3;  // r, g, b per entry

  logic [7:0] mem [DEPTH];
  logic [9:0] wr_slot;
  logic [9:0] rd_slot;

  // entry * 3 + cycle
  function automatic logic [9:0] slot(input logic [7:0] entry, input logic [1:0] cycle);
    return ({2'b00, entry} << 1) + {2'b00, entry} + {8'h00, cycle};
  endfunction

  assign wr_slot = slot(wr_i.entry, wr_i.cycle);
  assign rd_slot = slot(rd_i.entry, rd_i.cycle);  // rd_i.we unused by design

  always_ff @(posedge wb_clk_i)
  begin
    if (wr_i.we)
      mem[wr_slot] <= wr_i.wdata;
  end

  always_ff @(posedge wb_clk_i)
  begin
    rdata_o <= mem[rd_slot];  // one cycle latency
  end

endmodule

`default_nettype wire

// ==== rtl/vga_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_cfg.svh"

module vga_config_regs (
  input  wire                         wb_clk_i,
  input  wire                         arst_n_i,
  input  wire vga_pkg::wb_req_t       wb_req_i,
  output vga_pkg::wb_rsp_t            wb_rsp_o,
  output vga_pkg::gfx_ctrl_t          gfx_o,
  output vga_pkg::crtc_t              crtc_o,
  output vga_pkg::pal_port_t          pal_o,
  input  wire [7:0]                   pal_rdata_i,
  output vga_pkg::dac_port_t          dac_wr_o,
  output vga_pkg::dac_port_t          dac_rd_o,
  input  wire [7:0]                   dac_rdata_i,
  input  wire                         v_retrace_i,
  input  wire                         vh_retrace_i
);
  import vga_pkg::*;

  localparam int unsigned GFX_REGS  = 9;
  localparam int unsigned CRTC_REGS = 16;

  logic        wr;
  logic        rd;
  logic        wr_seq;
  logic        wr_gfx;
  logic        wr_crtc;
  logic [3:0]  seq_idx;
  logic [3:0]  gfx_idx;
  logic [3:0]  crtc_idx;
  logic [3:0]  seq_idx_nxt;
  logic [3:0]  gfx_idx_nxt;
  logic [3:0]  crtc_idx_nxt;
  logic [3:0]  map_mask;
  logic [7:0]  gfx_q [GFX_REGS];
  logic [7:0]  crtc_q [CRTC_REGS];
  attr_byte_u  attr_wr;
  logic        flip_flop;
  logic        pas;
  logic [3:0]  pal_idx;
  logic        wr_attr;
  logic        rd_attr;
  logic        clr_ff;
  logic        pel_rd_load;
  logic        pel_wr_load;
  logic        dac_wr_stb;
  logic        dac_rd_txn;
  logic        dac_rd_adv;
  logic [7:0]  wr_entry;
  logic [1:0]  wr_cycle;
  logic [7:0]  wr_entry_base;
  logic [1:0]  wr_cycle_base;
  logic [7:0]  rd_entry;
  logic [1:0]  rd_cycle;
  logic [1:0]  dac_state;
  logic        dly_rd;
  logic        ack_dly_q;
  logic [7:0]  gfx_sel;
  logic [15:0] rdata;

  // next pointer after one colour byte, wraps blue -> red of next entry
  function automatic logic [9:0] dac_step(input logic [7:0] entry, input logic [1:0] cycle);
    if (cycle == 2'd2)
      return {entry + 8'd1, 2'd0};
    else
      return {entry, cycle + 2'd1};
  endfunction

  assign wr = wb_req_i.stb & wb_req_i.we;
  assign rd = wb_req_i.stb & ~wb_req_i.we;

  assign wr_seq  = wr && (wb_req_i.adr == `VGA_ADR_SEQ);
  assign wr_gfx  = wr && (wb_req_i.adr == `VGA_ADR_GFX);
  assign wr_crtc = wr && (wb_req_i.adr == `VGA_ADR_CRTC);

  // byte 0 loads the index, byte 1 of the same word already sees it
  assign seq_idx_nxt  = (wr_seq && wb_req_i.sel[0]) ? wb_req_i.dat[3:0] : seq_idx;
  assign gfx_idx_nxt  = (wr_gfx && wb_req_i.sel[0]) ? wb_req_i.dat[3:0] : gfx_idx;
  assign crtc_idx_nxt = (wr_crtc && wb_req_i.sel[0]) ? wb_req_i.dat[3:0] : crtc_idx;

  // attribute port
  assign attr_wr = wb_req_i.dat[7:0];
  assign wr_attr = wr && (wb_req_i.adr == `VGA_ADR_ATTR) && wb_req_i.sel[0];
  assign rd_attr = rd && (wb_req_i.adr == `VGA_ADR_ATTR) && wb_req_i.sel[1];
  assign clr_ff  = rd && (wb_req_i.adr == `VGA_ADR_STATUS) && wb_req_i.sel[0];

  assign pal_o = '{addr: pal_idx, we: wr_attr & flip_flop & ~pas, wdata: attr_wr.color};

  // pel / dac address machinery
  assign pel_rd_load = wr && (wb_req_i.adr == `VGA_ADR_PEL_RD) && wb_req_i.sel[1];
  assign pel_wr_load = wr && (wb_req_i.adr == `VGA_ADR_PEL_WR) && wb_req_i.sel[0];
  assign dac_wr_stb  = wr && (wb_req_i.adr == `VGA_ADR_PEL_WR) && wb_req_i.sel[1];
  assign dac_rd_txn  = rd && (wb_req_i.adr == `VGA_ADR_PEL_WR) && wb_req_i.sel[1];
  assign dac_rd_adv  = dac_rd_txn && ack_dly_q && (dac_state == 2'd3);  // once, on ack

  // word write bypasses the entry register
  assign wr_entry_base = pel_wr_load ? wb_req_i.dat[7:0] : wr_entry;
  assign wr_cycle_base = pel_wr_load ? 2'd0 : wr_cycle;

  assign dac_wr_o = '{entry: wr_entry_base, cycle: wr_cycle_base, we: dac_wr_stb,
                      wdata: wb_req_i.dat[15:8]};
  assign dac_rd_o = '{entry: rd_entry, cycle: rd_cycle, we: 1'b0, wdata: 8'h00};

  // ram backed reads take one extra cycle
  assign dly_rd   = rd_attr | dac_rd_txn;
  assign wb_rsp_o = '{dat: rdata, ack: dly_rd ? ack_dly_q : wb_req_i.stb};

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ack_dly_q <= 1'b0;
    else
      ack_dly_q <= dly_rd & ~ack_dly_q;  // single pulse, then drop
  end

  // index registers and map mask
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      seq_idx  <= 4'h0;
      gfx_idx  <= 4'h0;
      crtc_idx <= 4'h0;
      map_mask <= 4'h0;
    end
    else
    begin
      seq_idx  <= seq_idx_nxt;
      gfx_idx  <= gfx_idx_nxt;
      crtc_idx <= crtc_idx_nxt;
      if (wr_seq && wb_req_i.sel[1] && (seq_idx_nxt == 4'h2))
        map_mask <= wb_req_i.dat[11:8];
    end
  end

  // graphics and crtc data banks
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < GFX_REGS; i++)
        gfx_q[i] <= 8'h00;
      for (int i = 0; i < CRTC_REGS; i++)
        crtc_q[i] <= 8'h00;
    end
    else
    begin
      if (wr_gfx && wb_req_i.sel[1] && (gfx_idx_nxt < GFX_REGS))  // 9..15 not mapped
        gfx_q[gfx_idx_nxt] <= wb_req_i.dat[15:8];
      if (wr_crtc && wb_req_i.sel[1])
        crtc_q[crtc_idx_nxt] <= wb_req_i.dat[15:8];
    end
  end

  // attribute flip-flop and palette index
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      flip_flop <= 1'b0;
      pas       <= 1'b0;
      pal_idx   <= 4'h0;
    end
    else
    begin
      if (clr_ff)
        flip_flop <= 1'b0;
      else if (wr_attr)
        flip_flop <= ~flip_flop;
      if (wr_attr && !flip_flop)  // index phase
      begin
        pas     <= attr_wr.idx.pas;
        pal_idx <= attr_wr.idx.index;
      end
    end
  end

  // dac pointers and state
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_entry  <= 8'h00;
      wr_cycle  <= 2'd0;
      rd_entry  <= 8'h00;
      rd_cycle  <= 2'd0;
      dac_state <= 2'd1;
    end
    else
    begin
      if (dac_wr_stb)
        {wr_entry, wr_cycle} <= dac_step(wr_entry_base, wr_cycle_base);
      else if (pel_wr_load)
        {wr_entry, wr_cycle} <= {wb_req_i.dat[7:0], 2'd0};
      if (pel_rd_load)
        {rd_entry, rd_cycle} <= {wb_req_i.dat[15:8], 2'd0};
      else if (dac_rd_adv)
        {rd_entry, rd_cycle} <= dac_step(rd_entry, rd_cycle);
      if (pel_rd_load)
        dac_state <= 2'd3;  // read mode
      else if (pel_wr_load)
        dac_state <= 2'd0;  // write mode
    end
  end

  // decoded config out
  always_comb
  begin
    gfx_o.shift_reg1       = gfx_q[5][6];
    gfx_o.graphics_alpha   = gfx_q[6][0];
    gfx_o.memory_mapping1  = gfx_q[6][3];
    gfx_o.write_mode       = gfx_q[5][1:0];
    gfx_o.raster_op        = gfx_q[3][4:3];
    gfx_o.read_mode        = gfx_q[5][3];
    gfx_o.bitmask          = gfx_q[8];
    gfx_o.set_reset        = gfx_q[0][3:0];
    gfx_o.enable_set_reset = gfx_q[1][3:0];
    gfx_o.read_map_select  = gfx_q[4][1:0];
    gfx_o.color_compare    = gfx_q[2][3:0];
    gfx_o.color_dont_care  = gfx_q[7][3:0];
  end

  assign crtc_o = '{cur_start:  crtc_q[10][5:0],
                    cur_end:    crtc_q[11][5:0],
                    start_addr: {crtc_q[12], crtc_q[13]},
                    vcursor:    crtc_q[14][4:0],
                    hcursor:    crtc_q[15][6:0]};

  assign gfx_sel = (gfx_idx < GFX_REGS) ? gfx_q[gfx_idx] : 8'h00;

  // readback, data byte high and index low like the write layout
  always_comb
  begin
    case (wb_req_i.adr)
      `VGA_ADR_ATTR:   rdata = {pal_rdata_i, 3'b001, pas, pal_idx};
      `VGA_ADR_SEQ:    rdata = {4'h0, map_mask, 4'h0, seq_idx};
      `VGA_ADR_PEL_RD: rdata = {6'h00, dac_state, 8'hFF};
      `VGA_ADR_PEL_WR: rdata = {dac_rdata_i, wr_entry};
      `VGA_ADR_GFX:    rdata = {gfx_sel, 4'h0, gfx_idx};
      `VGA_ADR_CRTC:   rdata = {crtc_q[crtc_idx], 4'h0, crtc_idx};
      `VGA_ADR_STATUS: rdata = {11'h000, v_retrace_i, 3'b000, vh_retrace_i};
      default:         rdata = 16'h0000;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/vga_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_regs_top (
  input  wire                     wb_clk_i,
  input  wire                     arst_n_i,
  input  wire vga_pkg::wb_req_t   wb_req_i,
  output vga_pkg::wb_rsp_t        wb_rsp_o,
  output vga_pkg::gfx_ctrl_t      gfx_o,
  output vga_pkg::crtc_t          crtc_o,
  input  wire                     v_retrace_i,
  input  wire                     vh_retrace_i
);
  import vga_pkg::*;

  pal_port_t  pal;        // regs -> palette
  logic [7:0] pal_rdata;
  dac_port_t  dac_wr;     // regs -> dac, write side
  dac_port_t  dac_rd;     // regs -> dac, read side
  logic [7:0] dac_rdata;

  vga_config_regs regs0 (
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .gfx_o        (gfx_o),
    .crtc_o       (crtc_o),
    .pal_o        (pal),
    .pal_rdata_i  (pal_rdata),
    .dac_wr_o     (dac_wr),
    .dac_rd_o     (dac_rd),
    .dac_rdata_i  (dac_rdata),
    .v_retrace_i  (v_retrace_i),
    .vh_retrace_i (vh_retrace_i)
  );

  vga_palette_ram pal0 (
    .wb_clk_i (wb_clk_i),
    .pal_i    (pal),
    .rdata_o  (pal_rdata)
  );

  vga_dac_ram dac0 (
    .wb_clk_i (wb_clk_i),
    .wr_i     (dac_wr),
    .rd_i     (dac_rd),
    .rdata_o  (dac_rdata)
  );

endmodule

`default_nettype wire

// ==== dv/vga_regs_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_cfg.svh"

module vga_regs_properties (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire vga_pkg::wb_req_t   req_i,
  input  wire vga_pkg::wb_rsp_t   rsp_i,
  input  wire vga_pkg::pal_port_t pal_i,
  input  wire                     pas_i
);
  import vga_pkg::*;

  logic dly_rd;  // palette or dac data read, ram backed

  assign dly_rd = req_i.stb && !req_i.we && req_i.sel[1] &&
                  ((req_i.adr == `VGA_ADR_ATTR) || (req_i.adr == `VGA_ADR_PEL_WR));

  // writes never wait
  write_ack_same_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.we |-> (rsp_i.ack == req_i.stb))
    else $error("write ack differs from strobe");

  // low on the first cycle, high on the second
  delayed_read_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(dly_rd) |-> !rsp_i.ack ##1 rsp_i.ack)
    else $error("delayed read ack not one cycle after strobe");

  pal_we_only_without_pas: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pal_i.we |-> !pas_i)
    else $error("palette written while pas set");

endmodule

bind vga_config_regs vga_regs_properties props0 (
  .clk_i    (wb_clk_i),
  .arst_n_i (arst_n_i),
  .req_i    (wb_req_i),
  .rsp_i    (wb_rsp_o),
  .pal_i    (pal_o),
  .pas_i    (pas)
);

`default_nettype wire

// ==== dv/vga_regs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_cfg.svh"

module vga_regs_tb;
  import vga_pkg::*;

  localparam int CLK_NS = 4;
  localparam int N_GFX  = 60;
  localparam int N_SEQ  = 8;
  localparam int N_ATTR = 16;
  localparam int N_DAC  = 40;
  localparam int N_STAT = 8;
  // upper bound on bus transactions over all tests
  localparam int N_TXN  = 3 * N_GFX + 2 * N_SEQ + 3 * N_ATTR + 3 * N_DAC + N_STAT + 60;

  logic       clk;
  logic       arst_n;
  wb_req_t    req;
  wb_rsp_t    rsp;
  gfx_ctrl_t  gfx;
  crtc_t      crtc;
  logic       v_ret;
  logic       vh_ret;
  int         seed;
  int         err_cnt;
  bit         ready;   // output compare enabled

  // shadow model
  logic [3:0] m_seq_idx;
  logic [3:0] m_map;
  logic [3:0] m_gfx_idx;
  logic [7:0] m_gfx [9];
  logic [3:0] m_crtc_idx;
  logic [7:0] m_crtc [16];
  logic       m_ff;
  logic       m_pas;
  logic [3:0] m_pal_idx;
  logic [7:0] m_pal [16];
  logic [7:0] m_dac [768];
  logic [7:0] m_wr_entry;
  logic [1:0] m_wr_cycle;
  logic [7:0] m_rd_entry;
  logic [1:0] m_rd_cycle;
  logic [1:0] m_state;

  logic [3:0] adr_list [9] = '{4'h1, 4'h5, 4'h6, 4'h8, 4'h9, 4'hB, 4'hC, 4'hE, 4'hF};

  vga_regs_top dut0 (
    .wb_clk_i     (clk),
    .arst_n_i     (arst_n),
    .wb_req_i     (req),
    .wb_rsp_o     (rsp),
    .gfx_o        (gfx),
    .crtc_o       (crtc),
    .v_retrace_i  (v_ret),
    .vh_retrace_i (vh_ret)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial
  begin
    #(N_TXN * 20 * CLK_NS);
    $display("timeout, the bus stopped answering before the tests completed");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  task automatic stop_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "first error, run stopped");
  endtask

  // only the selected bytes count
  task automatic check_word(input string what, input logic [15:0] got,
                            input logic [15:0] exp, input logic [1:0] sel);
    logic [15:0] mask;
    mask = {{8{sel[1]}}, {8{sel[0]}}};
    if ((got & mask) !== (exp & mask))
      stop_run($sformatf("ERROR %0t ns: %s read %h, expected %h", $time, what,
                         got & mask, exp & mask));
  endtask

  task automatic check_gfx(input gfx_ctrl_t got, input gfx_ctrl_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t ns: gfx_o %h, expected %h", $time, got, exp));
  endtask

  task automatic check_crtc(input crtc_t got, input crtc_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t ns: crtc_o %h, expected %h", $time, got, exp));
  endtask

  // three colour bytes per entry
  task automatic advance_pointer(inout logic [7:0] e, inout logic [1:0] c);
    if (c == 2'd2)
    begin
      c = 2'd0;
      e = e + 8'd1;
    end
    else
      c = c + 2'd1;
  endtask

  function automatic gfx_ctrl_t ref_gfx();
    gfx_ctrl_t g;
    g.shift_reg1       = m_gfx[5][6];
    g.graphics_alpha   = m_gfx[6][0];
    g.memory_mapping1  = m_gfx[6][3];
    g.write_mode       = m_gfx[5][1:0];
    g.raster_op        = m_gfx[3][4:3];  // function select
    g.read_mode        = m_gfx[5][3];
    g.bitmask          = m_gfx[8];
    g.set_reset        = m_gfx[0][3:0];
    g.enable_set_reset = m_gfx[1][3:0];
    g.read_map_select  = m_gfx[4][1:0];
    g.color_compare    = m_gfx[2][3:0];
    g.color_dont_care  = m_gfx[7][3:0];
    return g;
  endfunction

  function automatic crtc_t ref_crtc();
    crtc_t c;
    c.cur_start  = m_crtc[10][5:0];
    c.cur_end    = m_crtc[11][5:0];
    c.start_addr = {m_crtc[12], m_crtc[13]};  // high byte first
    c.vcursor    = m_crtc[14][4:0];
    c.hcursor    = m_crtc[15][6:0];
    return c;
  endfunction

  function automatic logic [15:0] ref_read(input logic [3:0] adr);
    logic [7:0] g;
    g = (m_gfx_idx < 4'd9) ? m_gfx[m_gfx_idx] : 8'h00;
    case (adr)
      `VGA_ADR_ATTR:   return {m_pal[m_pal_idx], 3'b001, m_pas, m_pal_idx};
      `VGA_ADR_SEQ:    return {4'h0, m_map, 4'h0, m_seq_idx};
      `VGA_ADR_PEL_RD: return {6'h00, m_state, 8'hFF};
      `VGA_ADR_PEL_WR: return {m_dac[int'(m_rd_entry) * 3 + int'(m_rd_cycle)], m_wr_entry};
      `VGA_ADR_GFX:    return {g, 4'h0, m_gfx_idx};
      `VGA_ADR_CRTC:   return {m_crtc[m_crtc_idx], 4'h0, m_crtc_idx};
      `VGA_ADR_STATUS: return {11'h000, v_ret, 3'b000, vh_ret};
      default:         return 16'h0000;
    endcase
  endfunction

  task automatic model_write(input logic [3:0] adr, input logic [1:0] sel,
                             input logic [15:0] dat);
    case (adr)
      `VGA_ADR_ATTR:
        if (sel[0])
        begin
          if (!m_ff)
          begin
            m_pas     = dat[4];
            m_pal_idx = dat[3:0];
          end
          else if (!m_pas)
            m_pal[m_pal_idx] = dat[7:0];
          m_ff = !m_ff;
        end
      `VGA_ADR_SEQ:
      begin
        if (sel[0])
          m_seq_idx = dat[3:0];
        if (sel[1] && m_seq_idx == 4'h2)
          m_map = dat[11:8];
      end
      `VGA_ADR_PEL_RD:
        if (sel[1])
        begin
          m_rd_entry = dat[15:8];
          m_rd_cycle = 2'd0;
          m_state    = 2'd3;
        end
      `VGA_ADR_PEL_WR:
      begin
        if (sel[0])
        begin
          m_wr_entry = dat[7:0];
          m_wr_cycle = 2'd0;
          m_state    = 2'd0;
        end
        if (sel[1])
        begin
          m_dac[int'(m_wr_entry) * 3 + int'(m_wr_cycle)] = dat[15:8];
          advance_pointer(m_wr_entry, m_wr_cycle);
        end
      end
      `VGA_ADR_GFX:
      begin
        if (sel[0])
          m_gfx_idx = dat[3:0];
        if (sel[1] && m_gfx_idx < 4'd9)
          m_gfx[m_gfx_idx] = dat[15:8];
      end
      `VGA_ADR_CRTC:
      begin
        if (sel[0])
          m_crtc_idx = dat[3:0];
        if (sel[1])
          m_crtc[m_crtc_idx] = dat[15:8];
      end
      default: ;
    endcase
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [1:0] sel,
                          input logic [15:0] dat);
    @(posedge clk);
    req <= '{dat: dat, adr: adr, we: 1'b1, sel: sel, stb: 1'b1};
    do
      @(posedge clk);
    while (!rsp.ack);
    req.stb <= 1'b0;
    model_write(adr, sel, dat);
  endtask

  // reads check themselves, including ack latency
  task automatic wb_read(input logic [3:0] adr, input logic [1:0] sel);
    int   n;
    logic dly;
    n   = 0;
    dly = sel[1] && (adr == `VGA_ADR_ATTR || adr == `VGA_ADR_PEL_WR);
    @(posedge clk);
    req <= '{dat: 16'h0000, adr: adr, we: 1'b0, sel: sel, stb: 1'b1};
    do
    begin
      @(posedge clk);
      n++;
    end
    while (!rsp.ack);
    req.stb <= 1'b0;
    if (n != (dly ? 2 : 1))
      stop_run($sformatf("read of word %h acknowledged after %0d cycles instead of %0d",
                         adr, n, dly ? 2 : 1));
    check_word($sformatf("word %h", adr), rsp.dat, ref_read(adr), sel);
    if (adr == `VGA_ADR_STATUS && sel[0])
      m_ff = 1'b0;
    if (adr == `VGA_ADR_PEL_WR && sel[1] && m_state == 2'd3)
      advance_pointer(m_rd_entry, m_rd_cycle);
  endtask

  // outputs settle by the falling edge
  always @(negedge clk)
  begin
    if (ready)
    begin
      check_gfx(gfx, ref_gfx());
      check_crtc(crtc, ref_crtc());
    end
  end

  initial
  begin
    logic [31:0] r;
    logic [3:0]  adr;
    logic [7:0]  start;
    logic [7:0]  entry2;
    int          n;
    req     = '0;
    arst_n  = 1'b0;
    v_ret   = 1'b0;
    vh_ret  = 1'b0;
    seed    = 32'h9427926b;
    err_cnt = 0;
    ready   = 1'b0;
    {m_seq_idx, m_map, m_gfx_idx, m_crtc_idx, m_pal_idx} = '0;
    {m_ff, m_pas, m_wr_entry, m_wr_cycle, m_rd_entry, m_rd_cycle} = '0;
    m_state = 2'd1;
    foreach (m_gfx[i]) m_gfx[i] = 8'h00;
    foreach (m_crtc[i]) m_crtc[i] = 8'h00;
    foreach (m_pal[i]) m_pal[i] = 8'h00;
    foreach (m_dac[i]) m_dac[i] = 8'h00;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    ready = 1'b1;

    // graphics and crtc banks
    for (int i = 0; i < N_GFX; i++)
    begin
      r   = $random(seed);
      adr = r[0] ? `VGA_ADR_GFX : `VGA_ADR_CRTC;
      case (r[17:16])
        2'd0:
        begin
          wb_write(adr, 2'b01, {8'h00, 4'h0, r[7:4]});
          wb_write(adr, 2'b10, {r[15:8], 8'h00});
        end
        2'd2: wb_write(adr, 2'b01, {r[15:8], 4'h0, r[7:4]});  // data must stay
        default: wb_write(adr, 2'b11, {r[15:8], 4'h0, r[7:4]});
      endcase
      wb_read(adr, 2'b11);
    end

    // map mask, only index 2
    for (int i = 0; i < N_SEQ; i++)
    begin
      r = $random(seed);
      wb_write(`VGA_ADR_SEQ, (r[6:5] == 2'b00) ? 2'b11 : r[6:5],
               {r[15:8], 4'h0, r[4] ? 4'h2 : r[3:0]});
      wb_read(`VGA_ADR_SEQ, 2'b11);
    end

    // attribute palette, index then data
    wb_read(`VGA_ADR_STATUS, 2'b01);
    for (int i = 0; i < N_ATTR; i++)
    begin
      r = $random(seed);
      wb_write(`VGA_ADR_ATTR, 2'b01, {8'h00, 4'h0, 4'(i)});
      wb_write(`VGA_ADR_ATTR, 2'b01, {8'h00, r[7:0]});
      wb_read(`VGA_ADR_ATTR, 2'b11);
    end
    wb_write(`VGA_ADR_ATTR, 2'b01, 16'h0015);  // pas set, index 5
    wb_write(`VGA_ADR_ATTR, 2'b01, 16'h00AA);  // dropped
    wb_read(`VGA_ADR_ATTR, 2'b11);

    // dac write auto increment
    r      = $random(seed);
    start  = r[7:0];
    entry2 = start + 8'd64;
    n      = 24 + int'(r[11:8]);
    wb_write(`VGA_ADR_PEL_WR, 2'b01, {8'h00, start});
    for (int k = 0; k < n; k++)
    begin
      r = $random(seed);
      wb_write(`VGA_ADR_PEL_WR, 2'b10, {r[7:0], 8'h00});
    end
    wb_read(`VGA_ADR_PEL_WR, 2'b01);
    r = $random(seed);
    wb_write(`VGA_ADR_PEL_WR, 2'b11, {r[15:8], entry2});  // red, cycle left at 1
    wb_read(`VGA_ADR_PEL_WR, 2'b01);
    wb_write(`VGA_ADR_PEL_WR, 2'b10, {r[23:16], 8'h00});   // green

    // dac read back
    wb_read(`VGA_ADR_PEL_RD, 2'b11);
    wb_write(`VGA_ADR_PEL_RD, 2'b10, {start, 8'h00});
    wb_read(`VGA_ADR_PEL_RD, 2'b11);
    for (int k = 0; k < n; k++)
      wb_read(`VGA_ADR_PEL_WR, 2'b10);
    wb_write(`VGA_ADR_PEL_RD, 2'b10, {entry2, 8'h00});
    wb_read(`VGA_ADR_PEL_WR, 2'b10);
    wb_read(`VGA_ADR_PEL_WR, 2'b10);
    wb_write(`VGA_ADR_PEL_WR, 2'b01, 16'h0000);
    wb_read(`VGA_ADR_PEL_RD, 2'b11);

    // status bits and unmapped words
    for (int i = 0; i < N_STAT; i++)
    begin
      r = $random(seed);
      @(posedge clk);
      v_ret  <= r[0];
      vh_ret <= r[1];
      wb_read(`VGA_ADR_STATUS, 2'b11);
    end
    foreach (adr_list[i])
      wb_read(adr_list[i], 2'b11);

    if (err_cnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vga_regs.f ====
+incdir+rtl
rtl/vga_pkg.sv
rtl/vga_palette_ram.sv
rtl/vga_dac_ram.sv
rtl/vga_config_regs.sv
rtl/vga_regs_top.sv
dv/vga_regs_properties.sv
dv/vga_regs_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vga_regs.f \
		--top-module vga_regs_tb -Mdir obj_dir

run: compile
	./obj_dir/Vvga_regs_tb > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
